// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing -Wno-fatal -j 0
TOP       = tb_video
FILELIST  = build.f
OBJ_DIR   = obj_dir
BIN       = $(OBJ_DIR)/V$(TOP)
SOURCES   = $(wildcard *.sv *.svh)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)

// File: background_memory.sv
`include "video_defines.svh"

module background_memory (
  input  logic                 clk,
  input  logic                 wr_en,
  input  video_pkg::bg_write_t wr,
  input  video_pkg::coord_t    fetch,
  output video_pkg::rgb565_t   pixel
);
  import video_pkg::*;

  localparam int ADDR_BITS = `BG_ADDR_BITS;
  localparam int DEPTH = 1 << ADDR_BITS;

  rgb565_t              mem [DEPTH];
  logic [ADDR_BITS-1:0] rd_addr;

  // Row-major, one line per VID_WIDTH words
  assign rd_addr = ADDR_BITS'(fetch.y * `VID_WIDTH + fetch.x);

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr.addr] <= wr.data;
    end
  end

  // Blanking positions read junk, masked later by de
  always_ff @(posedge clk) begin
    pixel <= mem[rd_addr];
  end

endmodule

// File: build.f
+incdir+.
video_pkg.sv
write_port.sv
video_timing.sv
background_memory.sv
lcd_renderer.sv
pixel_compositor.sv
video_top.sv
tb_video.sv

// File: lcd_renderer.sv
`include "video_defines.svh"

module lcd_renderer (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  wr_en,
  input  video_pkg::seg_write_t wr,
  input  video_pkg::raster_t    raster,
  output logic                  lit
);
  logic [`LCD_ROWS*`LCD_COLS-1:0] seg_bits;

  // Segment pattern from the host
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      seg_bits <= '0;
    end else if (wr_en) begin
      seg_bits <= wr.seg_bits;
    end
  end

  // Lines up with the registered background read
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      lit <= 1'b0;
    end else begin
      lit <= raster.in_lcd && seg_bits[raster.seg_index];
    end
  end

endmodule

// File: pixel_compositor.sv
`include "video_defines.svh"

module pixel_compositor (
  input  logic               clk,
  input  logic               rst_n,
  input  video_pkg::rgb565_t bg,
  input  logic               lit,
  input  video_pkg::raster_t raster,
  output video_pkg::rgb888_t rgb,
  output video_pkg::raster_t sync
);
  import video_pkg::*;

  // Black foreground, so only the background share survives
  localparam logic [7:0] BG_WEIGHT = 8'hff - `LCD_ALPHA;

  raster_t raster_d;  // Same pixel as bg and lit
  rgb888_t bg888;
  rgb888_t blended;

  function automatic logic [7:0] dim(logic [7:0] c);
    logic [15:0] p;
    p = {8'd0, c} * {8'd0, BG_WEIGHT};
    return p[15:8];
  endfunction

  // Top bits repeated into the low bits
  assign bg888.r = {bg[15:11], bg[15:13]};
  assign bg888.g = {bg[10:5], bg[10:9]};
  assign bg888.b = {bg[4:0], bg[4:2]};

  assign blended.r = lit ? dim(bg888.r) : bg888.r;
  assign blended.g = lit ? dim(bg888.g) : bg888.g;
  assign blended.b = lit ? dim(bg888.b) : bg888.b;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      raster_d <= '0;
      sync     <= '0;
      rgb      <= '0;
    end else begin
      raster_d <= raster;
      sync     <= raster_d;
      rgb      <= raster_d.de ? blended : '0;
    end
  end

endmodule

// File: tb_video.sv
`include "video_defines.svh"

module tb_video;
  import video_pkg::*;

  localparam int LIMIT = 1000;  // Cycles allowed per wait
  localparam int H_TOTAL = `VID_WIDTH + `VID_HBLANK_LEN;
  localparam int V_TOTAL = `VID_HEIGHT + `VID_VBLANK_LEN;

  logic       clk;
  logic       rst_n;
  logic       bg_req;
  logic       bg_ack;
  bg_write_t  bg_payload;
  logic       seg_req;
  logic       seg_ack;
  seg_write_t seg_payload;
  rgb888_t    rgb;
  logic       hsync;
  logic       vsync;
  logic       hblank;
  logic       vblank;
  logic       de;

  rgb565_t                        model_mem [1 << `BG_ADDR_BITS];
  logic [`LCD_ROWS*`LCD_COLS-1:0] seg_model;
  logic [31:0]                    lfsr;

  video_top u_dut (.*);

  always #10 clk = ~clk;

  // *********************************************************************
  // Checks
  // *********************************************************************

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Finished with errors");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_pixel(input rgb888_t got, input rgb888_t exp, input string what);
    if (got !== exp)
      fail_run($sformatf("[ERROR] %0t: %s got %h expected %h", $time, what, got, exp));
  endtask

  task automatic check_ack(input logic got, input logic exp, input string what);
    if (got !== exp)
      fail_run($sformatf("[ERROR] %0t: %s got %b expected %b", $time, what, got, exp));
  endtask

  task automatic check_level(input logic got, input logic exp, input string what);
    if (got !== exp)
      fail_run($sformatf("[ERROR] %0t: %s got %b expected %b", $time, what, got, exp));
  endtask

  task automatic check_count(input int got, input int exp, input string what);
    if (got != exp)
      fail_run($sformatf("[ERROR] %0t: %s got %0d expected %0d", $time, what, got, exp));
  endtask

  // Galois LFSR, one step per bit
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic rgb565_t random_word();
    rgb565_t w;
    w = '0;
    for (int i = 0; i < 16; i++) begin
      w    = {w[14:0], lfsr[0]};
      lfsr = lfsr_step(lfsr);
    end
    return w;
  endfunction

  // Reference pixel for visible index idx
  function automatic rgb888_t expected_pixel(input int idx);
    rgb888_t e;
    rgb565_t v;
    int      x;
    int      y;
    int      r5;
    int      g6;
    int      b5;
    logic    lit;
    x  = idx % `VID_WIDTH;
    y  = idx / `VID_WIDTH;
    v  = model_mem[idx];
    r5 = int'(v[15:11]);
    g6 = int'(v[10:5]);
    b5 = int'(v[4:0]);
    e.r = 8'((r5 << 3) | (r5 >> 2));
    e.g = 8'((g6 << 2) | (g6 >> 4));
    e.b = 8'((b5 << 3) | (b5 >> 2));
    lit = 1'b0;
    if (x >= `LCD_X_OFFSET && x < `LCD_X_OFFSET + `LCD_COLS * `LCD_PIXEL_SIZE &&
        y >= `LCD_Y_OFFSET && y < `LCD_Y_OFFSET + `LCD_ROWS * `LCD_PIXEL_SIZE)
      lit = seg_model[((y - `LCD_Y_OFFSET) / `LCD_PIXEL_SIZE) * `LCD_COLS +
                      (x - `LCD_X_OFFSET) / `LCD_PIXEL_SIZE];
    if (lit) begin
      e.r = 8'((int'(e.r) * (255 - int'(`LCD_ALPHA))) / 256);
      e.g = 8'((int'(e.g) * (255 - int'(`LCD_ALPHA))) / 256);
      e.b = 8'((int'(e.b) * (255 - int'(`LCD_ALPHA))) / 256);
    end
    return e;
  endfunction

  // *********************************************************************
  // Host writes
  // *********************************************************************

  function automatic logic ack_of(input bit use_seg);
    return use_seg ? seg_ack : bg_ack;
  endfunction

  task automatic handshake(input bit use_seg, input string name);
    int n;
    check_ack(ack_of(use_seg), 1'b0, {name, " ack before req"});
    if (use_seg) seg_req = 1'b1;
    else bg_req = 1'b1;
    n = 0;
    while (ack_of(use_seg) !== 1'b1) begin
      @(negedge clk);
      n++;
      if (n > LIMIT) fail_run({name, " ack did not rise after req"});
    end
    repeat (2) begin  // Held while req stays high
      @(negedge clk);
      check_ack(ack_of(use_seg), 1'b1, {name, " ack while req high"});
    end
    if (use_seg) seg_req = 1'b0;
    else bg_req = 1'b0;
    n = 0;
    while (ack_of(use_seg) !== 1'b0) begin
      @(negedge clk);
      n++;
      if (n > LIMIT) fail_run({name, " ack did not fall after req dropped"});
    end
  endtask

  task automatic write_bg(input logic [7:0] addr, input rgb565_t data);
    bg_payload.addr = addr;
    bg_payload.data = data;
    handshake(1'b0, "background");
    model_mem[addr] = data;
  endtask

  task automatic write_seg(input logic [7:0] bits);
    seg_payload.seg_bits = bits;
    handshake(1'b1, "segment");
    seg_model = bits;
  endtask

  // *********************************************************************
  // Frame capture
  // *********************************************************************

  task automatic wait_vsync(input logic level);
    int n;
    n = 0;
    while (vsync !== level) begin
      @(negedge clk);
      n++;
      if (n > LIMIT) fail_run("vsync did not reach the expected level");
    end
  endtask

  // One frame, vsync to vsync
  task automatic check_frame();
    int   cycles;
    int   pixels;
    int   runs;
    int   run_len;
    int   hs_pulses;
    int   vs_cycles;
    int   x_pos;
    int   row;
    logic prev_vs;
    logic prev_hs;
    logic prev_de;
    wait_vsync(1'b0);
    wait_vsync(1'b1);
    cycles = 0;
    pixels = 0;
    runs = 0;
    run_len = 0;
    hs_pulses = 0;
    vs_cycles = 0;
    prev_vs = 1'b1;
    prev_hs = 1'b0;
    prev_de = 1'b0;
    do begin
      x_pos = cycles % H_TOTAL;
      row   = (cycles / H_TOTAL) % V_TOTAL;  // Blank lines come first
      check_level(hblank, x_pos >= `VID_WIDTH, "hblank");
      check_level(vblank, row < `VID_VBLANK_LEN, "vblank");
      check_level(hsync, x_pos == `VID_WIDTH, "hsync");
      check_level(de, x_pos < `VID_WIDTH && row >= `VID_VBLANK_LEN, "de");
      if (de) begin
        check_pixel(rgb, expected_pixel(pixels), $sformatf("pixel %0d", pixels));
        pixels++;
        run_len++;
      end else begin
        check_pixel(rgb, '0, "rgb outside de");
        if (prev_de) begin
          check_count(run_len, `VID_WIDTH, "de run length");
          runs++;
          run_len = 0;
        end
      end
      if (hsync && !prev_hs) hs_pulses++;
      if (vsync) vs_cycles++;
      prev_de = de;
      prev_hs = hsync;
      prev_vs = vsync;
      @(negedge clk);
      cycles++;
      if (cycles > 2 * H_TOTAL * V_TOTAL) fail_run("frame did not end with a second vsync");
    end while (!(vsync && !prev_vs));
    check_count(cycles, H_TOTAL * V_TOTAL, "cycles per frame");
    check_count(pixels, `VID_WIDTH * `VID_HEIGHT, "de pixels per frame");
    check_count(runs, `VID_HEIGHT, "de runs per frame");
    check_count(hs_pulses, V_TOTAL, "hsync pulses per frame");
    check_count(vs_cycles, H_TOTAL, "vsync cycles per frame");
  endtask

  initial begin
    int          fd;
    int          code;
    int          ch;
    int          n;
    int          frames;
    logic [7:0]  cmd;
    logic [31:0] a;
    logic [31:0] b;
    clk = 1'b0;
    rst_n = 1'b0;
    bg_req = 1'b0;
    seg_req = 1'b0;
    bg_payload = '0;
    seg_payload = '0;
    seg_model = '0;
    lfsr = 32'hf560_ac37;
    frames = 0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    check_level(de, 1'b0, "de after reset");
    n = 0;
    while (de !== 1'b1) begin  // Quiet until the first visible pixel
      check_ack(bg_ack, 1'b0, "background ack after reset");
      check_ack(seg_ack, 1'b0, "segment ack after reset");
      check_level(hsync, 1'b0, "hsync after reset");
      check_level(vsync, 1'b0, "vsync after reset");
      check_pixel(rgb, '0, "rgb after reset");
      @(negedge clk);
      n++;
      if (n > LIMIT) fail_run("de never rose after reset");
    end

    fd = $fopen("video_tests.txt", "r");
    if (fd == 0) fail_run("could not open video_tests.txt");
    while ($fscanf(fd, " %c", cmd) == 1) begin
      case (cmd)
        "#": begin
          ch = $fgetc(fd);
          while (ch != 10 && ch != -1) ch = $fgetc(fd);
        end
        "B": begin
          code = $fscanf(fd, " %h %h", a, b);
          if (code != 2) fail_run("bad B line in video_tests.txt");
          write_bg(a[7:0], b[15:0]);
        end
        "R": begin
          code = $fscanf(fd, " %h %h", a, b);
          if (code != 2) fail_run("bad R line in video_tests.txt");
          for (int i = 0; i < int'(b); i++) write_bg(8'(int'(a) + i), random_word());
        end
        "S": begin
          code = $fscanf(fd, " %h", a);
          if (code != 1) fail_run("bad S line in video_tests.txt");
          write_seg(a[7:0]);
        end
        "F": begin
          check_frame();
          frames++;
        end
        default: fail_run("unknown command in video_tests.txt");
      endcase
    end
    $fclose(fd);

    if (frames == 0) begin
      fail_run("no frame was checked");
    end else begin
      $display("Finished with no errors");
      $finish;
    end
  end

endmodule

// File: video_defines.svh
`ifndef VIDEO_DEFINES_SVH
`define VIDEO_DEFINES_SVH

// *********************************************************************
// Raster geometry
// *********************************************************************

// Visible area
`define VID_WIDTH      16
`define VID_HEIGHT     12

// Blanking
`define VID_HBLANK_LEN 4
`define VID_VBLANK_LEN 2

// *********************************************************************
// LCD area
// *********************************************************************

// Centred over the visible area
`define LCD_X_OFFSET   4
`define LCD_Y_OFFSET   4
`define LCD_COLS       4
`define LCD_ROWS       2
`define LCD_PIXEL_SIZE 2

// Blend weight of a lit segment
`define LCD_ALPHA      8'hc0

`define BG_ADDR_BITS   8

`endif

// File: video_pkg.sv
`include "video_defines.svh"

package video_pkg;

  typedef logic [15:0] rgb565_t;  // r[15:11] g[10:5] b[4:0]

  typedef struct packed {
    logic [7:0] r;
    logic [7:0] g;
    logic [7:0] b;
  } rgb888_t;

  typedef struct packed {
    logic [4:0] x;
    logic [4:0] y;
  } coord_t;

  // Host writes
  typedef struct packed {
    logic [`BG_ADDR_BITS-1:0] addr;
    rgb565_t                  data;
  } bg_write_t;

  typedef struct packed {
    logic [`LCD_ROWS*`LCD_COLS-1:0] seg_bits;  // Bit row * LCD_COLS + col
  } seg_write_t;

  // Per-pixel timing and LCD flags
  typedef struct packed {
    logic       hsync;
    logic       vsync;
    logic       hblank;
    logic       vblank;
    logic       de;
    logic       in_lcd;
    logic [2:0] seg_index;
  } raster_t;

endpackage

// File: video_tests.txt
# Cmd and hex fields: B addr data (background), R addr count (LFSR fill),
# S bits (segments, row*4+col), F (check one frame), # comment
R 00 c0
S 00
F
B 00 ffff
B 05 f800
B 2a 07e0
B 55 001f
B 66 ffff
B 44 8410
S a5
F
S 5a
F
S ff
F
S 01
F

// File: video_timing.sv
`include "video_defines.svh"

module video_timing (
  input  logic               clk,
  input  logic               rst_n,
  output video_pkg::coord_t  fetch,
  output video_pkg::raster_t raster
);
  import video_pkg::*;

  localparam int H_TOTAL = `VID_WIDTH + `VID_HBLANK_LEN;
  localparam int V_TOTAL = `VID_HEIGHT + `VID_VBLANK_LEN;
  localparam int LCD_W = `LCD_COLS * `LCD_PIXEL_SIZE;
  localparam int LCD_H = `LCD_ROWS * `LCD_PIXEL_SIZE;
  localparam logic [4:0] LCD_X0 = `LCD_X_OFFSET;
  localparam logic [4:0] LCD_Y0 = `LCD_Y_OFFSET;

  coord_t fetch_next;

  // Next raster position, wrapping at the end of line and frame
  function automatic coord_t step(coord_t p);
    coord_t n;
    n = p;
    if (p.x == H_TOTAL - 1) begin
      n.x = '0;
      n.y = (p.y == V_TOTAL - 1) ? 5'd0 : p.y + 5'd1;
    end else begin
      n.x = p.x + 5'd1;
    end
    return n;
  endfunction

  function automatic raster_t decode(coord_t p);
    raster_t    r;
    logic [4:0] col;
    logic [4:0] row;
    col = 5'((p.x - LCD_X0) / `LCD_PIXEL_SIZE);
    row = 5'((p.y - LCD_Y0) / `LCD_PIXEL_SIZE);
    r.de     = (p.x < `VID_WIDTH) && (p.y < `VID_HEIGHT);
    r.hblank = p.x >= `VID_WIDTH;
    r.hsync  = p.x == `VID_WIDTH;   // First blank pixel
    r.vblank = p.y >= `VID_HEIGHT;
    r.vsync  = p.y == `VID_HEIGHT;  // First blank line
    r.in_lcd = (p.x >= LCD_X0) && (p.x < LCD_X0 + LCD_W) &&
               (p.y >= LCD_Y0) && (p.y < LCD_Y0 + LCD_H);
    r.seg_index = r.in_lcd ? 3'(row * `LCD_COLS + col) : 3'd0;
    return r;
  endfunction

  assign fetch_next = step(fetch);

  // *********************************************************************
  // Counters and flag pipeline
  // *********************************************************************

  // Flags decoded one pixel ahead, so raster always describes fetch
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      fetch  <= '0;
      raster <= decode('0);
    end else begin
      fetch  <= fetch_next;
      raster <= decode(fetch_next);
    end
  end

endmodule

// File: video_top.sv
module video_top (
  input  logic                  clk,
  input  logic                  rst_n,

  input  logic                  bg_req,
  output logic                  bg_ack,
  input  video_pkg::bg_write_t  bg_payload,

  input  logic                  seg_req,
  output logic                  seg_ack,
  input  video_pkg::seg_write_t seg_payload,

  output video_pkg::rgb888_t    rgb,
  output logic                  hsync,
  output logic                  vsync,
  output logic                  hblank,
  output logic                  vblank,
  output logic                  de
);
  import video_pkg::*;

  coord_t     fetch;
  raster_t    raster;
  raster_t    sync;
  rgb565_t    bg_pixel;
  logic       lit;
  logic       bg_wr_en;
  bg_write_t  bg_wr;
  logic       seg_wr_en;
  seg_write_t seg_wr;

  // *********************************************************************
  // Host write ports
  // *********************************************************************

  write_port #(
    .payload_t(bg_write_t)
  ) bg_port (
    .clk    (clk),
    .rst_n  (rst_n),
    .req    (bg_req),
    .ack    (bg_ack),
    .payload(bg_payload),
    .wr_en  (bg_wr_en),
    .wr_data(bg_wr)
  );

  write_port #(
    .payload_t(seg_write_t)
  ) seg_port (
    .clk    (clk),
    .rst_n  (rst_n),
    .req    (seg_req),
    .ack    (seg_ack),
    .payload(seg_payload),
    .wr_en  (seg_wr_en),
    .wr_data(seg_wr)
  );

  // *********************************************************************
  // Video pipeline
  // *********************************************************************

  video_timing timing (
    .clk   (clk),
    .rst_n (rst_n),
    .fetch (fetch),
    .raster(raster)
  );

  background_memory background (
    .clk  (clk),
    .wr_en(bg_wr_en),
    .wr   (bg_wr),
    .fetch(fetch),
    .pixel(bg_pixel)
  );

  lcd_renderer lcd (
    .clk   (clk),
    .rst_n (rst_n),
    .wr_en (seg_wr_en),
    .wr    (seg_wr),
    .raster(raster),
    .lit   (lit)
  );

  pixel_compositor compositor (
    .clk   (clk),
    .rst_n (rst_n),
    .bg    (bg_pixel),
    .lit   (lit),
    .raster(raster),
    .rgb   (rgb),
    .sync  (sync)
  );

  assign hsync  = sync.hsync;
  assign vsync  = sync.vsync;
  assign hblank = sync.hblank;
  assign vblank = sync.vblank;
  assign de     = sync.de;

endmodule

// File: write_port.sv
module write_port #(
  parameter type payload_t = logic [7:0]
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     req,
  output logic     ack,
  input  payload_t payload,
  output logic     wr_en,
  output payload_t wr_data
);
  typedef enum logic {
    IDLE,
    HELD   // Ack high until req drops
  } state_t;

  state_t state;
  logic   accept;

  assign accept = (state == IDLE) && req;
  assign ack    = (state == HELD);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= IDLE;
      wr_en <= 1'b0;
    end else begin
      wr_en <= accept;  // One strobe per handshake
      case (state)
        IDLE:    if (req) state <= HELD;
        HELD:    if (!req) state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) wr_data <= payload;
  end

endmodule
